// ==== flist.f ====
verilog/ide_types_pkg.sv
verilog/ide_timing_pkg.sv
verilog/ide_req_if.sv
verilog/ide_request_router.sv
verilog/ide_pio_channel.sv
verilog/ide_read_collect.sv
verilog/ide_subsys.sv
verification/tb_ide_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_ide_subsys
FLIST     := flist.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := TEST RESULT: FAIL
SOURCES   := $(wildcard verilog/*.sv verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_ide_subsys.sv ====
/*
 * Testbench for the two-channel IDE PIO host controller.
 * Disk models on both channels, directed and random Z80 and DMA traffic,
 * every completion checked against a shadow copy of the disk contents.
 */
`timescale 1ns/1ps

module tb_ide_subsys;

	localparam int PERIOD = 20;
	localparam int N_RAND = 200;
	// directed transfers plus the random run
	localparam int N_XFER = 9 + N_RAND;
	localparam int WATCHDOG_NS = (N_XFER * 8 + 200) * PERIOD;

	typedef struct packed {
		logic        dma;
		logic        chan;
		logic [2:0]  a;
		logic        rnw;
		logic [15:0] wdata;
		logic [15:0] rdata;
	} xfer_t;

	logic clk;
	logic reset;
	logic z80_req;
	logic z80_chan;
	logic z80_rnw;
	logic [2:0] z80_a;
	logic z80_cs0_n;
	logic z80_cs1_n;
	logic [15:0] z80_wdata;
	logic dma_req;
	logic dma_chan;
	logic dma_rnw;
	logic [15:0] dma_wdata;
	logic z80_done;
	logic dma_done;
	logic [15:0] z80_rdata;
	logic [15:0] dma_rdata;
	logic [1:0][15:0] ide_d_in;
	logic [1:0][15:0] ide_d_out;
	logic [1:0] ide_d_oe;
	logic [1:0][2:0] ide_a;
	logic [1:0] ide_dir;
	logic [1:0] ide_cs0_n;
	logic [1:0] ide_cs1_n;
	logic [1:0] ide_rd_n;
	logic [1:0] ide_wr_n;

	// shadow of what the disks should hold
	logic [15:0] shadow [2][8];
	logic written [2][8];
	xfer_t done_q [$];
	logic [31:0] lfsr;
	int cyc;
	int errors;
	int checks;
	int z80_reqs;
	int dma_reqs;
	int z80_dones;
	int dma_dones;
	int strobe_len [2];
	logic overlap_seen;

	// random run, drawn up front
	logic rnd_dma [N_RAND];
	logic rnd_chan [N_RAND];
	logic rnd_rnw [N_RAND];
	logic [2:0] rnd_a [N_RAND];
	logic rnd_sel [N_RAND];
	logic [15:0] rnd_data [N_RAND];

	ide_subsys dut (
		.clk       (clk),
		.reset     (reset),
		.z80_req   (z80_req),
		.z80_chan  (z80_chan),
		.z80_rnw   (z80_rnw),
		.z80_a     (z80_a),
		.z80_cs0_n (z80_cs0_n),
		.z80_cs1_n (z80_cs1_n),
		.z80_wdata (z80_wdata),
		.dma_req   (dma_req),
		.dma_chan  (dma_chan),
		.dma_rnw   (dma_rnw),
		.dma_wdata (dma_wdata),
		.z80_done  (z80_done),
		.dma_done  (dma_done),
		.z80_rdata (z80_rdata),
		.dma_rdata (dma_rdata),
		.ide_d_in  (ide_d_in),
		.ide_d_out (ide_d_out),
		.ide_d_oe  (ide_d_oe),
		.ide_a     (ide_a),
		.ide_dir   (ide_dir),
		.ide_cs0_n (ide_cs0_n),
		.ide_cs1_n (ide_cs1_n),
		.ide_rd_n  (ide_rd_n),
		.ide_wr_n  (ide_wr_n)
	);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	// one disk per channel, eight task-file words
	for (genvar c = 0; c < 2; c++)
	begin : g_disk
		logic [15:0] regs [8];

		initial
		begin
			for (int i = 0; i < 8; i++)
				regs[i] = (16'h1d00 ^ 16'(i)) + 16'(c * 256);
		end

		// word lands when wr_n rises
		always @(posedge ide_wr_n[c])
		begin
			if (!reset)
				regs[ide_a[c]] = ide_d_out[c];
		end

		// floating bus reads as all ones
		assign ide_d_in[c] = ide_rd_n[c] ? 16'hffff : regs[ide_a[c]];
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// last word written, else the power-up pattern
	function automatic logic [15:0] expected_read(input logic chan, input logic [2:0] a);
		if (written[chan][a])
			return shadow[chan][a];
		return ({13'd0, a} ^ 16'h1d00) + (chan ? 16'h0100 : 16'h0000);
	endfunction

	task automatic log_completion(input logic is_dma, input logic chan, input logic [2:0] a,
		input logic rnw, input logic [15:0] wdata, input logic [15:0] rdata,
		input bit solo, input int req_cyc, input int done_cyc);
		xfer_t rec;
		// launch is the edge after the request goes up
		if (solo)
			assert (done_cyc - req_cyc - 1 == 4)
			else
			begin
				errors++;
				$display("MISMATCH t=%0t done %0d cycles after launch, expected 4",
					$time, done_cyc - req_cyc - 1);
			end
		rec.dma = is_dma;
		rec.chan = chan;
		rec.a = a;
		rec.rnw = rnw;
		rec.wdata = wdata;
		rec.rdata = rdata;
		done_q.push_back(rec);
	endtask

	task automatic z80_access(input logic chan, input logic rnw, input logic [2:0] a,
		input logic sel, input logic [15:0] wdata, input bit solo, output int done_cyc);
		int req_cyc;
		@(posedge clk);
		#1;
		z80_chan = chan;
		z80_rnw = rnw;
		z80_a = a;
		z80_cs0_n = sel;
		z80_cs1_n = ~sel;
		z80_wdata = wdata;
		z80_req = 1'b1;
		req_cyc = cyc;
		z80_reqs++;
		do
		begin
			@(negedge clk);
			// task-file register and chip select as issued
			if (solo && (!ide_rd_n[chan] || !ide_wr_n[chan]))
				assert (ide_a[chan] == a && ide_cs0_n[chan] == sel && ide_cs1_n[chan] == !sel)
				else
				begin
					errors++;
					$display("MISMATCH t=%0t z80 cycle a=%0d cs0_n=%b cs1_n=%b", $time,
						ide_a[chan], ide_cs0_n[chan], ide_cs1_n[chan]);
				end
		end
		while (!z80_done);
		done_cyc = cyc;
		log_completion(1'b0, chan, a, rnw, wdata, z80_rdata, solo, req_cyc, done_cyc);
		@(posedge clk);
		#1;
		z80_req = 1'b0;
	endtask

	task automatic dma_access(input logic chan, input logic rnw, input logic [15:0] wdata,
		input bit solo, output int done_cyc);
		int req_cyc;
		@(posedge clk);
		#1;
		dma_chan = chan;
		dma_rnw = rnw;
		dma_wdata = wdata;
		dma_req = 1'b1;
		req_cyc = cyc;
		dma_reqs++;
		do
		begin
			@(negedge clk);
			// data register through cs0 while the strobe is low
			if (solo && (!ide_rd_n[chan] || !ide_wr_n[chan]))
				assert (ide_a[chan] == 3'd0 && !ide_cs0_n[chan] && ide_cs1_n[chan])
				else
				begin
					errors++;
					$display("MISMATCH t=%0t dma cycle a=%0d cs0_n=%b cs1_n=%b", $time,
						ide_a[chan], ide_cs0_n[chan], ide_cs1_n[chan]);
				end
		end
		while (!dma_done);
		done_cyc = cyc;
		log_completion(1'b1, chan, 3'd0, rnw, wdata, dma_rdata, solo, req_cyc, done_cyc);
		@(posedge clk);
		#1;
		dma_req = 1'b0;
	endtask

	// walks the random list, taking only this source's entries
	task automatic run_source(input logic is_dma);
		int unused_cyc;
		for (int i = 0; i < N_RAND; i++)
		begin
			if (rnd_dma[i] == is_dma)
			begin
				if (is_dma)
					dma_access(rnd_chan[i], rnd_rnw[i], rnd_data[i], 1'b0, unused_cyc);
				else
					z80_access(rnd_chan[i], rnd_rnw[i], rnd_a[i], rnd_sel[i], rnd_data[i],
						1'b0, unused_cyc);
			end
		end
	endtask

	// completions are queued at negedge, drained here in completion order
	always @(posedge clk)
	begin : compare_results
		xfer_t r;
		logic [15:0] exp;
		while (done_q.size() > 0)
		begin
			r = done_q.pop_front();
			checks++;
			if (r.rnw)
			begin
				exp = expected_read(r.chan, r.a);
				assert (r.rdata == exp)
				else
				begin
					errors++;
					$display("MISMATCH t=%0t %s read ch%0d a=%0d got %h expected %h", $time,
						r.dma ? "dma" : "z80", r.chan, r.a, r.rdata, exp);
				end
			end
			else
			begin
				shadow[r.chan][r.a] = r.wdata;
				written[r.chan][r.a] = 1'b1;
			end
		end
	end

	// done counts, strobe width, pad direction and overlap between the channels
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (z80_done)
				z80_dones++;
			if (dma_done)
				dma_dones++;
			for (int c = 0; c < 2; c++)
			begin
				if (!ide_rd_n[c] || !ide_wr_n[c])
					strobe_len[c]++;
				else if (strobe_len[c] != 0)
				begin
					assert (strobe_len[c] == 2)
					else
					begin
						errors++;
						$display("MISMATCH t=%0t ch%0d strobe low for %0d cycles, expected 2",
							$time, c, strobe_len[c]);
					end
					strobe_len[c] = 0;
				end
				// host drives the pads on writes only, released when idle
				if (!ide_wr_n[c])
				begin
					assert (!ide_dir[c] && ide_d_oe[c])
					else
					begin
						errors++;
						$display("MISMATCH t=%0t ch%0d write with dir=%b oe=%b", $time, c,
							ide_dir[c], ide_d_oe[c]);
					end
				end
				else if (!ide_rd_n[c] || (ide_cs0_n[c] && ide_cs1_n[c]))
				begin
					assert (ide_dir[c] && !ide_d_oe[c])
					else
					begin
						errors++;
						$display("MISMATCH t=%0t ch%0d read or idle with dir=%b oe=%b", $time,
							c, ide_dir[c], ide_d_oe[c]);
					end
				end
			end
			if ((!ide_rd_n[0] || !ide_wr_n[0]) && (!ide_rd_n[1] || !ide_wr_n[1]))
				overlap_seen = 1'b1;
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, transfers still pending", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		logic [31:0] v;
		int t_z80;
		int t_dma;
		reset = 1'b1;
		z80_req = 1'b0;
		z80_chan = 1'b0;
		z80_rnw = 1'b0;
		z80_a = 3'd0;
		z80_cs0_n = 1'b1;
		z80_cs1_n = 1'b1;
		z80_wdata = 16'h0000;
		dma_req = 1'b0;
		dma_chan = 1'b0;
		dma_rnw = 1'b0;
		dma_wdata = 16'h0000;
		overlap_seen = 1'b0;
		lfsr = 32'hb2d2971e;
		for (int c = 0; c < 2; c++)
			for (int i = 0; i < 8; i++)
				written[c][i] = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// idle levels right after reset
		repeat (3)
		begin
			@(negedge clk);
			assert (&ide_cs0_n && &ide_cs1_n && &ide_rd_n && &ide_wr_n && ide_d_oe == 2'b00
				&& !z80_done && !dma_done)
			else
			begin
				errors++;
				$display("MISMATCH t=%0t outputs not idle after reset", $time);
			end
		end

		// z80 write then read back, uncontended
		z80_access(1'b0, 1'b0, 3'd5, 1'b0, 16'h5a3c, 1'b1, t_z80);
		z80_access(1'b0, 1'b1, 3'd5, 1'b0, 16'h0000, 1'b1, t_z80);

		// dma on the data register
		dma_access(1'b1, 1'b0, 16'hbeef, 1'b1, t_dma);
		dma_access(1'b1, 1'b1, 16'h0000, 1'b1, t_dma);
		dma_access(1'b0, 1'b1, 16'h0000, 1'b1, t_dma);

		// same channel at once, dma write must land before the z80 read
		fork
			z80_access(1'b1, 1'b1, 3'd0, 1'b0, 16'h0000, 1'b0, t_z80);
			dma_access(1'b1, 1'b0, 16'hd0a1, 1'b0, t_dma);
		join
		assert (t_z80 > t_dma)
		else
		begin
			errors++;
			$display("ERROR at %0t: z80 was served before dma on a shared channel", $time);
		end

		// different channels run side by side
		overlap_seen = 1'b0;
		fork
			z80_access(1'b0, 1'b1, 3'd2, 1'b1, 16'h0000, 1'b0, t_z80);
			dma_access(1'b1, 1'b1, 16'h0000, 1'b0, t_dma);
		join
		assert (overlap_seen)
		else
		begin
			errors++;
			$display("ERROR at %0t: the two channels never strobed in the same cycle", $time);
		end

		for (int i = 0; i < N_RAND; i++)
		begin
			draw(1, v);
			rnd_dma[i] = v[0];
			draw(1, v);
			rnd_chan[i] = v[0];
			draw(1, v);
			rnd_rnw[i] = v[0];
			draw(3, v);
			rnd_a[i] = v[2:0];
			draw(1, v);
			rnd_sel[i] = v[0];
			draw(16, v);
			rnd_data[i] = v[15:0];
		end
		fork
			run_source(1'b0);
			run_source(1'b1);
		join

		repeat (3) @(posedge clk);
		assert (z80_dones == z80_reqs && dma_dones == dma_reqs)
		else
		begin
			errors++;
			$display("MISMATCH t=%0t done strobes z80 %0d/%0d dma %0d/%0d", $time,
				z80_dones, z80_reqs, dma_dones, dma_reqs);
		end
		$display("checks %0d, errors %0d, z80 done %0d of %0d, dma done %0d of %0d",
			checks, errors, z80_dones, z80_reqs, dma_dones, dma_reqs);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== verilog/ide_subsys.sv ====
/*
 * Two-channel IDE PIO host controller top level.
 * Plain ports toward the Z80 and DMA sides; drive-side ports are packed
 * per channel, the board top builds the tristate data pads.
 */
`timescale 1ns/1ps

module ide_subsys (
	input  logic                                                   clk,
	input  logic                                                   reset,
	input  logic                                                   z80_req,
	input  ide_types_pkg::ide_chan_t                               z80_chan,
	input  logic                                                   z80_rnw,
	input  ide_types_pkg::ide_addr_t                               z80_a,
	input  logic                                                   z80_cs0_n,
	input  logic                                                   z80_cs1_n,
	input  ide_types_pkg::ide_data_t                               z80_wdata,
	input  logic                                                   dma_req,
	input  ide_types_pkg::ide_chan_t                               dma_chan,
	input  logic                                                   dma_rnw,
	input  ide_types_pkg::ide_data_t                               dma_wdata,
	output logic                                                   z80_done,
	output logic                                                   dma_done,
	output ide_types_pkg::ide_data_t                               z80_rdata,
	output ide_types_pkg::ide_data_t                               dma_rdata,
	input  ide_types_pkg::ide_data_t [ide_types_pkg::NUM_CHAN-1:0] ide_d_in,
	output ide_types_pkg::ide_data_t [ide_types_pkg::NUM_CHAN-1:0] ide_d_out,
	output logic [ide_types_pkg::NUM_CHAN-1:0]                     ide_d_oe,
	output ide_types_pkg::ide_addr_t [ide_types_pkg::NUM_CHAN-1:0] ide_a,
	output logic [ide_types_pkg::NUM_CHAN-1:0]                     ide_dir,
	output logic [ide_types_pkg::NUM_CHAN-1:0]                     ide_cs0_n,
	output logic [ide_types_pkg::NUM_CHAN-1:0]                     ide_cs1_n,
	output logic [ide_types_pkg::NUM_CHAN-1:0]                     ide_rd_n,
	output logic [ide_types_pkg::NUM_CHAN-1:0]                     ide_wr_n
);
	import ide_types_pkg::*;

	// one request bundle per engine
	ide_req_if chan_if [NUM_CHAN] ();

	ide_request_router u_router (
		.clk       (clk),
		.reset     (reset),
		.z80_req   (z80_req),
		.z80_chan  (z80_chan),
		.z80_rnw   (z80_rnw),
		.z80_a     (z80_a),
		.z80_cs0_n (z80_cs0_n),
		.z80_cs1_n (z80_cs1_n),
		.z80_wdata (z80_wdata),
		.dma_req   (dma_req),
		.dma_chan  (dma_chan),
		.dma_rnw   (dma_rnw),
		.dma_wdata (dma_wdata),
		.chan_if   (chan_if)
	);

	for (genvar i = 0; i < NUM_CHAN; i++)
	begin : g_chan
		ide_pio_channel u_chan (
			.clk       (clk),
			.reset     (reset),
			.ide_d_in  (ide_d_in[i]),
			.bus       (chan_if[i]),
			.ide_d_out (ide_d_out[i]),
			.ide_d_oe  (ide_d_oe[i]),
			.ide_a     (ide_a[i]),
			.ide_dir   (ide_dir[i]),
			.ide_cs0_n (ide_cs0_n[i]),
			.ide_cs1_n (ide_cs1_n[i]),
			.ide_rd_n  (ide_rd_n[i]),
			.ide_wr_n  (ide_wr_n[i])
		);
	end

	ide_read_collect u_collect (
		.clk       (clk),
		.reset     (reset),
		.chan_if   (chan_if),
		.z80_done  (z80_done),
		.dma_done  (dma_done),
		.z80_rdata (z80_rdata),
		.dma_rdata (dma_rdata)
	);

endmodule

// ==== verilog/ide_read_collect.sv ====
/*
 * Collects channel completions into per-source done strobes and read data.
 * Read data is valid in the done cycle and held until the next read.
 */
`timescale 1ns/1ps

module ide_read_collect (
	input  logic                     clk,
	input  logic                     reset,
	ide_req_if.collector             chan_if [ide_types_pkg::NUM_CHAN],
	output logic                     z80_done,
	output logic                     dma_done,
	output ide_types_pkg::ide_data_t z80_rdata,
	output ide_types_pkg::ide_data_t dma_rdata
);
	import ide_types_pkg::*;

	logic [NUM_CHAN-1:0] z80_stb_v;
	logic [NUM_CHAN-1:0] dma_stb_v;
	logic [NUM_CHAN-1:0] z80_din_v;
	logic [NUM_CHAN-1:0] dma_din_v;
	ide_data_t           rdata_v [NUM_CHAN];
	ide_data_t           z80_rdata_q;
	ide_data_t           dma_rdata_q;

	// split each channel's strobes by the tag latched at launch
	for (genvar i = 0; i < NUM_CHAN; i++)
	begin : g_chan
		assign z80_stb_v[i] = chan_if[i].rdy_stb && (chan_if[i].done_src == SRC_Z80);
		assign dma_stb_v[i] = chan_if[i].rdy_stb && (chan_if[i].done_src == SRC_DMA);
		assign z80_din_v[i] = chan_if[i].din_stb && (chan_if[i].done_src == SRC_Z80);
		assign dma_din_v[i] = chan_if[i].din_stb && (chan_if[i].done_src == SRC_DMA);
		assign rdata_v[i]   = chan_if[i].rdata;
	end

	assign z80_done = |z80_stb_v;
	assign dma_done = |dma_stb_v;

	// fresh word bypasses the holding register during din_stb
	always_comb
	begin
		z80_rdata = z80_rdata_q;
		dma_rdata = dma_rdata_q;
		for (int i = 0; i < NUM_CHAN; i++)
		begin
			if (z80_din_v[i])
				z80_rdata = rdata_v[i];
			if (dma_din_v[i])
				dma_rdata = rdata_v[i];
		end
	end

	always_ff @(posedge clk)
	begin
		z80_rdata_q <= z80_rdata;
		dma_rdata_q <= dma_rdata;
	end

	// each source has one request out, so two channels never finish for it at once
	a_one_done: assert property (@(posedge clk) disable iff (reset)
		$onehot0(z80_stb_v) && $onehot0(dma_stb_v))
		else $error("two channels completed for the same source");

endmodule

// ==== verilog/ide_pio_channel.sv ====
/*
 * One IDE channel engine running the five-step PIO4 cycle.
 * Launches on req while rdy, drives cs, dir and strobes from the
 * latched command and reports completion with one-cycle strobes.
 */
`timescale 1ns/1ps

module ide_pio_channel (
	input  logic                     clk,
	input  logic                     reset,
	input  ide_types_pkg::ide_data_t ide_d_in,
	ide_req_if.channel               bus,
	output ide_types_pkg::ide_data_t ide_d_out,
	output logic                     ide_d_oe,
	output ide_types_pkg::ide_addr_t ide_a,
	output logic                     ide_dir,
	output logic                     ide_cs0_n,
	output logic                     ide_cs1_n,
	output logic                     ide_rd_n,
	output logic                     ide_wr_n
);
	import ide_types_pkg::*;
	import ide_timing_pkg::*;

	ide_step_t st;
	logic      go;
	logic      rnw_q;
	ide_src_t  src_q;
	ide_addr_t a_q;
	ide_data_t wdata_q;
	ide_data_t rdata_q;

	// launch when a request meets an idle chain
	assign go = bus.req && bus.rdy;

	assign bus.rdy      = ~|st;
	assign bus.rdy_stb  = st[ST_DONE];
	// reads only
	assign bus.din_stb  = st[ST_DONE] && rnw_q;
	assign bus.done_src = src_q;
	assign bus.rdata    = rdata_q;

	// drive side from latched command
	assign ide_a     = a_q;
	assign ide_d_out = wdata_q;
	// dir low means host drives the bus
	assign ide_d_oe  = ~ide_dir;

	// one-hot step chain, go enters at bit 0
	always_ff @(posedge clk)
	begin
		if (reset)
			st <= '0;
		else
			st <= {st[ST_LEN-2:0], go};
	end

	// command latched at launch, held for the whole cycle
	always_ff @(posedge clk)
	begin
		if (go)
		begin
			rnw_q   <= bus.rnw;
			src_q   <= bus.src;
			a_q     <= bus.a;
			wdata_q <= bus.wdata;
		end
	end

	// sample at the strobe release, drive still holds data here
	always_ff @(posedge clk)
	begin
		if (st[ST_STROBE_OFF] && rnw_q)
			rdata_q <= ide_d_in;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ide_dir   <= 1'b1;
			ide_cs0_n <= 1'b1;
			ide_cs1_n <= 1'b1;
			ide_rd_n  <= 1'b1;
			ide_wr_n  <= 1'b1;
		end
		// E0, address setup with cs and dir
		else if (go)
		begin
			ide_dir   <= bus.rnw;
			ide_cs0_n <= bus.cs0_n;
			ide_cs1_n <= bus.cs1_n;
		end
		// E1, strobe falls
		else if (st[ST_STROBE_ON])
		begin
			ide_rd_n <= ~rnw_q;
			ide_wr_n <= rnw_q;
		end
		// E3, strobe rises after two cycles
		else if (st[ST_STROBE_OFF])
		begin
			ide_rd_n <= 1'b1;
			ide_wr_n <= 1'b1;
		end
		// E4, back to idle, bus released
		else if (st[ST_RELEASE])
		begin
			ide_dir   <= 1'b1;
			ide_cs0_n <= 1'b1;
			ide_cs1_n <= 1'b1;
		end
	end

	// a launch on rdy finds the cable already released by the last cycle
	a_launch_idle: assert property (@(posedge clk) disable iff (reset)
		go |-> ide_cs0_n && ide_cs1_n && ide_rd_n && ide_wr_n && ide_dir)
		else $error("channel launched while the previous cycle still held the bus");

	a_strobe_excl: assert property (@(posedge clk) disable iff (reset)
		!(!ide_rd_n && !ide_wr_n))
		else $error("rd_n and wr_n low together");

endmodule

// ==== verilog/ide_request_router.sv ====
/*
 * Steers the Z80 and DMA requests onto the channel engines.
 * DMA wins a channel when both target it; the loser keeps its level up.
 */
`timescale 1ns/1ps

module ide_request_router (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     z80_req,
	input  ide_types_pkg::ide_chan_t z80_chan,
	input  logic                     z80_rnw,
	input  ide_types_pkg::ide_addr_t z80_a,
	input  logic                     z80_cs0_n,
	input  logic                     z80_cs1_n,
	input  ide_types_pkg::ide_data_t z80_wdata,
	input  logic                     dma_req,
	input  ide_types_pkg::ide_chan_t dma_chan,
	input  logic                     dma_rnw,
	input  ide_types_pkg::ide_data_t dma_wdata,
	ide_req_if.router                chan_if [ide_types_pkg::NUM_CHAN]
);
	import ide_types_pkg::*;

	logic [NUM_CHAN-1:0] dma_hit;
	logic [NUM_CHAN-1:0] z80_hit;
	logic [NUM_CHAN-1:0] stb_v;
	ide_src_t            src_v [NUM_CHAN];
	logic                z80_done_now;
	logic                dma_done_now;
	logic                z80_hold_q;
	logic                dma_hold_q;
	ide_chan_t           z80_chan_q;
	ide_chan_t           dma_chan_q;
	logic                z80_rnw_q;
	logic                dma_rnw_q;

	for (genvar i = 0; i < NUM_CHAN; i++)
	begin : g_chan
		// which sources aim at this channel
		assign dma_hit[i] = dma_req && (dma_chan == ide_chan_t'(i));
		assign z80_hit[i] = z80_req && (z80_chan == ide_chan_t'(i));

		assign chan_if[i].req   = dma_hit[i] || z80_hit[i];
		// dma takes the channel, z80 just waits behind it
		assign chan_if[i].src   = dma_hit[i] ? SRC_DMA : SRC_Z80;
		assign chan_if[i].rnw   = dma_hit[i] ? dma_rnw : z80_rnw;
		assign chan_if[i].wdata = dma_hit[i] ? dma_wdata : z80_wdata;
		// dma always hits the data register, cs0 block
		assign chan_if[i].a     = dma_hit[i] ? '0 : z80_a;
		assign chan_if[i].cs0_n = dma_hit[i] ? 1'b0 : z80_cs0_n;
		assign chan_if[i].cs1_n = dma_hit[i] ? 1'b1 : z80_cs1_n;

		assign stb_v[i] = chan_if[i].rdy_stb;
		assign src_v[i] = chan_if[i].done_src;
	end

	// completion seen this cycle, per source
	always_comb
	begin
		z80_done_now = 1'b0;
		dma_done_now = 1'b0;
		for (int i = 0; i < NUM_CHAN; i++)
		begin
			if (stb_v[i] && (src_v[i] == SRC_Z80))
				z80_done_now = 1'b1;
			if (stb_v[i] && (src_v[i] == SRC_DMA))
				dma_done_now = 1'b1;
		end
	end

	// request still owed a done strobe at the next edge
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			z80_hold_q <= 1'b0;
			dma_hold_q <= 1'b0;
		end
		else
		begin
			z80_hold_q <= z80_req && !z80_done_now;
			dma_hold_q <= dma_req && !dma_done_now;
		end
	end

	always_ff @(posedge clk)
	begin
		z80_chan_q <= z80_chan;
		z80_rnw_q  <= z80_rnw;
		dma_chan_q <= dma_chan;
		dma_rnw_q  <= dma_rnw;
	end

	// a pending request stays up on the same channel and direction until done
	a_z80_held: assert property (@(posedge clk) disable iff (reset)
		z80_hold_q |-> z80_req && (z80_chan == z80_chan_q) && (z80_rnw == z80_rnw_q))
		else $error("z80 request changed or dropped before done");

	a_dma_held: assert property (@(posedge clk) disable iff (reset)
		dma_hold_q |-> dma_req && (dma_chan == dma_chan_q) && (dma_rnw == dma_rnw_q))
		else $error("dma request changed or dropped before done");

endmodule

// ==== verilog/ide_req_if.sv ====
/*
 * Request and completion bundle between the router, one channel engine
 * and the read collector. One instance per channel.
 */
`timescale 1ns/1ps

interface ide_req_if;
	import ide_types_pkg::*;

	// command from the router, held while the source waits
	logic      req;
	ide_src_t  src;
	logic      rnw;
	ide_data_t wdata;
	ide_addr_t a;
	logic      cs0_n;
	logic      cs1_n;

	// status back from the engine
	logic      rdy;
	logic      rdy_stb;
	logic      din_stb;
	ide_src_t  done_src;
	ide_data_t rdata;

	// router only needs completions to track held requests
	modport router (output req, src, rnw, wdata, a, cs0_n, cs1_n, input rdy_stb, done_src);
	modport channel (input req, src, rnw, wdata, a, cs0_n, cs1_n,
		output rdy, rdy_stb, din_stb, done_src, rdata);
	modport collector (input rdy_stb, din_stb, done_src, rdata);

endinterface

// ==== verilog/ide_timing_pkg.sv ====
/*
 * Step layout of the PIO4 cycle run by each channel engine.
 * The chain holds one live bit per cycle after launch.
 */
package ide_timing_pkg;

	// five cycles from launch to done
	localparam int ST_LEN = 5;

	typedef logic [ST_LEN-1:0] ide_step_t;

	// rd_n or wr_n falls at the edge after this step
	localparam int ST_STROBE_ON = 0;
	// strobe rises and read data is sampled
	localparam int ST_STROBE_OFF = 2;
	// cs and dir go back to idle
	localparam int ST_RELEASE = 3;
	// completion strobes are high during this step
	localparam int ST_DONE = 4;

endpackage

// ==== verilog/ide_types_pkg.sv ====
/*
 * Shared widths, source tags and channel count for the IDE host controller.
 * Imported by the router, channel engines, collector and top level.
 */
package ide_types_pkg;

	// one word on the drive data bus
	typedef logic [15:0] ide_data_t;

	// task-file register address, da[2:0] on the cable
	typedef logic [2:0] ide_addr_t;

	// channel select width, the engine count follows from it
	localparam int CHAN_W = 1;
	localparam int NUM_CHAN = 1 << CHAN_W;

	typedef logic [CHAN_W-1:0] ide_chan_t;

	// request source tag, carried through an engine and back to the collector
	typedef logic [0:0] ide_src_t;

	// z80 side, full task-file access
	localparam ide_src_t SRC_Z80 = 1'b0;
	// dma engine, data register only
	localparam ide_src_t SRC_DMA = 1'b1;

endpackage
